//--- mipsLite.f
+incdir+source
source/mipsLitePkg.sv
source/execCtrlIf.sv
source/controlUnit.sv
source/regFile.sv
source/aluUnit.sv
source/branchUnit.sv
source/fetchUnit.sv
source/writebackUnit.sv
source/mipsLite.sv
test/mipsLite_asserts.sv
test/mipsLiteTb.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
TOP = mipsLiteTb
FILELIST = mipsLite.f
LOG = sim.log
PASS = All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- test/mipsLiteTb.sv
`include "mipsLite_cfg.svh"

module mipsLiteTb;
	timeunit 1ns;
	timeprecision 100ps;
	import mipsLitePkg::*;

	localparam int MEM_WORDS = 256;
	// frame interrupts are only applied in the first cycles after reset
	localparam int WINDOW = 12;

	logic clk;
	logic rst;
	logic stall;
	logic frameInterrupt;
	logic [31:0] instruction;
	logic [31:0] icacheAddr;
	logic [31:0] dcacheAddr;
	logic dcacheWe;
	logic dcacheRe;
	logic [31:0] dcacheDin;
	logic [31:0] dcacheDout = 32'd0;
	logic [31:0] gpCode;
	logic [31:0] gpFrame;
	logic gpValid;

	logic [31:0] imem [MEM_WORDS];
	logic [31:0] dmem [MEM_WORDS];
	logic [31:0] prog [$];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	logic [31:0] endAddr;
	logic [31:0] lastFrame;
	logic seedMem;
	int progLen = 0;
	int nextEvent = 0;
	bit irqWin [WINDOW];
	bit stallWin [WINDOW];

	mipsLite UUT (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.frameInterrupt(frameInterrupt),
		.instruction(instruction),
		.icacheAddr(icacheAddr),
		.dcacheAddr(dcacheAddr),
		.dcacheWe(dcacheWe),
		.dcacheRe(dcacheRe),
		.dcacheDin(dcacheDin),
		.dcacheDout(dcacheDout),
		.gpCode(gpCode),
		.gpFrame(gpFrame),
		.gpValid(gpValid)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// instruction memory answers in the same cycle
	assign instruction = imem[icacheAddr[9:2]];

	function automatic logic [31:0] seedWord(input int i);
		return (32'(i) + 32'd1) * 32'h9e37_79b9;
	endfunction

	// data memory with one cycle of read latency
	always @(posedge clk) begin
		if (seedMem) begin
			for (int i = 0; i < MEM_WORDS; i++) begin
				dmem[i] <= seedWord(i);
			end
		end else if (dcacheWe) begin
			dmem[dcacheAddr[9:2]] <= dcacheDin;
		end
		if (dcacheRe) begin
			dcacheDout <= dmem[dcacheAddr[9:2]];
		end
	end

	function automatic logic [31:0] rType(input functT fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] sa);
		return {OP_RTYPE, rs, rt, rd, sa, fn};
	endfunction

	function automatic logic [31:0] iType(input opcodeT op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jType(input opcodeT op, input int idx);
		return {op, 26'(idx)};
	endfunction

	task automatic buildProgram();
		int jalAt;
		int endIdx;
		prog.delete();
		prog.push_back(iType(OP_LUI, 5'd1, 5'd0, 16'h1000));
		prog.push_back(iType(OP_ADDIU, 5'd2, 5'd0, 16'h1234));
		prog.push_back(iType(OP_ADDIU, 5'd3, 5'd0, 16'hfffb));
		// dependent chain where every result comes from forwarding
		prog.push_back(rType(FN_ADDU, 5'd4, 5'd2, 5'd3, 5'd0));
		prog.push_back(iType(OP_SW, 5'd4, 5'd1, 16'd0));
		prog.push_back(rType(FN_SUBU, 5'd5, 5'd4, 5'd2, 5'd0));
		prog.push_back(iType(OP_SW, 5'd5, 5'd1, 16'd4));
		prog.push_back(rType(FN_AND, 5'd6, 5'd5, 5'd2, 5'd0));
		prog.push_back(rType(FN_OR, 5'd7, 5'd6, 5'd3, 5'd0));
		prog.push_back(rType(FN_XOR, 5'd8, 5'd7, 5'd4, 5'd0));
		prog.push_back(iType(OP_SW, 5'd8, 5'd1, 16'd8));
		prog.push_back(rType(FN_SLT, 5'd9, 5'd3, 5'd2, 5'd0));
		prog.push_back(iType(OP_SW, 5'd9, 5'd1, 16'd12));
		prog.push_back(rType(FN_SLL, 5'd10, 5'd0, 5'd2, 5'd4));
		prog.push_back(rType(FN_SRL, 5'd11, 5'd0, 5'd10, 5'd3));
		prog.push_back(iType(OP_SW, 5'd11, 5'd1, 16'd16));
		prog.push_back(iType(OP_ORI, 5'd12, 5'd3, 16'h8001));
		prog.push_back(iType(OP_SW, 5'd12, 5'd1, 16'd20));
		prog.push_back(iType(OP_LUI, 5'd13, 5'd0, 16'habcd));
		prog.push_back(iType(OP_SW, 5'd13, 5'd1, 16'd24));
		// load followed at once by its use
		prog.push_back(iType(OP_LW, 5'd14, 5'd1, 16'd64));
		prog.push_back(rType(FN_ADDU, 5'd15, 5'd14, 5'd2, 5'd0));
		prog.push_back(iType(OP_SW, 5'd15, 5'd1, 16'd28));
		// taken beq skips one store after the slot
		prog.push_back(iType(OP_BEQ, 5'd2, 5'd2, 16'd2));
		prog.push_back(iType(OP_SW, 5'd2, 5'd1, 16'd32));
		prog.push_back(iType(OP_SW, 5'd3, 5'd1, 16'd36));
		prog.push_back(iType(OP_BNE, 5'd2, 5'd2, 16'd2));
		prog.push_back(iType(OP_SW, 5'd4, 5'd1, 16'd40));
		prog.push_back(iType(OP_SW, 5'd5, 5'd1, 16'd44));
		prog.push_back(iType(OP_BEQ, 5'd3, 5'd2, 16'd2));
		prog.push_back(iType(OP_ADDIU, 5'd20, 5'd0, 16'd1));
		prog.push_back(iType(OP_SW, 5'd20, 5'd1, 16'd48));
		prog.push_back(iType(OP_BNE, 5'd3, 5'd2, 16'd2));
		prog.push_back(iType(OP_SW, 5'd6, 5'd1, 16'd52));
		prog.push_back(iType(OP_SW, 5'd7, 5'd1, 16'd56));
		jalAt = prog.size();
		prog.push_back(32'd0);
		prog.push_back(iType(OP_ADDIU, 5'd21, 5'd0, 16'd7));
		prog.push_back(iType(OP_SW, 5'd31, 5'd1, 16'd60));
		prog.push_back(jType(OP_J, prog.size() + 3));
		prog.push_back(iType(OP_ADDIU, 5'd22, 5'd0, 16'd9));
		prog.push_back(iType(OP_SW, 5'd3, 5'd1, 16'd80));
		prog.push_back(iType(OP_SW, 5'd22, 5'd1, 16'd84));
		// graphics registers and frame counter
		prog.push_back(iType(OP_LUI, 5'd16, 5'd0, 16'h8000));
		prog.push_back(iType(OP_ADDIU, 5'd17, 5'd0, 16'h0055));
		prog.push_back(iType(OP_SW, 5'd17, 5'd16, 16'h0040));
		prog.push_back(iType(OP_ADDIU, 5'd18, 5'd0, 16'h0077));
		prog.push_back(iType(OP_SW, 5'd18, 5'd16, 16'h0030));
		prog.push_back(iType(OP_LW, 5'd19, 5'd16, 16'h0050));
		prog.push_back(iType(OP_SW, 5'd19, 5'd1, 16'd76));
		endIdx = prog.size();
		prog.push_back(jType(OP_J, endIdx));
		prog.push_back(32'd0);
		// subroutine called by jal
		prog[jalAt] = jType(OP_JAL, prog.size());
		prog.push_back(iType(OP_SW, 5'd21, 5'd1, 16'd68));
		prog.push_back(rType(FN_JR, 5'd0, 5'd31, 5'd0, 5'd0));
		prog.push_back(iType(OP_SW, 5'd31, 5'd1, 16'd72));
		for (int i = 0; i < MEM_WORDS; i++) begin
			imem[i] = (i < prog.size()) ? prog[i] : 32'd0;
		end
		endAddr = `RESET_VECTOR + 32'(endIdx * 4);
		progLen = prog.size();
	endtask

	// ISA level model with a delay slot that builds the expected write list
	function automatic void modelRun(input logic [31:0] frames);
		logic [31:0] r [32];
		logic [31:0] mem [MEM_WORDS];
		logic [31:0] pc;
		logic [31:0] npc;
		logic [31:0] nextNpc;
		logic [31:0] inst;
		logic [31:0] addr;
		logic [31:0] sImm;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		int steps;
		for (int i = 0; i < 32; i++) begin
			r[i] = 32'd0;
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = seedWord(i);
		end
		expAddr.delete();
		expData.delete();
		pc = `RESET_VECTOR;
		npc = pc + 32'd4;
		steps = 0;
		while (pc != endAddr && steps < 1000) begin
			inst = imem[pc[9:2]];
			rs = inst[25:21];
			rt = inst[20:16];
			rd = inst[15:11];
			sImm = {{16{inst[15]}}, inst[15:0]};
			addr = r[rs] + sImm;
			nextNpc = npc + 32'd4;
			case (inst[31:26])
				OP_RTYPE: begin
					case (inst[5:0])
						FN_ADDU: r[rd] = r[rs] + r[rt];
						FN_SUBU: r[rd] = r[rs] - r[rt];
						FN_AND: r[rd] = r[rs] & r[rt];
						FN_OR: r[rd] = r[rs] | r[rt];
						FN_XOR: r[rd] = r[rs] ^ r[rt];
						FN_SLT: r[rd] = ($signed(r[rs]) < $signed(r[rt])) ? 32'd1 : 32'd0;
						FN_SLL: r[rd] = r[rt] << inst[10:6];
						FN_SRL: r[rd] = r[rt] >> inst[10:6];
						FN_JR: nextNpc = r[rs];
						default: ;
					endcase
				end
				OP_ADDIU: r[rt] = addr;
				OP_ORI: r[rt] = r[rs] | {16'd0, inst[15:0]};
				OP_LUI: r[rt] = {inst[15:0], 16'd0};
				OP_LW: begin
					if (addr[31:28] == `DEVICE_NIBBLE) begin
						r[rt] = (addr == `FRAME_COUNT_ADDR) ? frames : 32'd0;
					end else begin
						r[rt] = mem[addr[9:2]];
					end
				end
				OP_SW: begin
					if (addr[31:28] != `DEVICE_NIBBLE) begin
						mem[addr[9:2]] = r[rt];
					end
					if (addr[31:28] != `DEVICE_NIBBLE || addr == `GP_CODE_ADDR ||
						addr == `GP_FRAME_ADDR) begin
						expAddr.push_back(addr);
						expData.push_back(r[rt]);
					end
				end
				OP_BEQ: if (r[rs] == r[rt]) nextNpc = npc + {sImm[29:0], 2'b00};
				OP_BNE: if (r[rs] != r[rt]) nextNpc = npc + {sImm[29:0], 2'b00};
				OP_J: nextNpc = {npc[31:28], inst[25:0], 2'b00};
				OP_JAL: begin
					r[31] = pc + 32'd8;
					nextNpc = {npc[31:28], inst[25:0], 2'b00};
				end
				default: ;
			endcase
			r[0] = 32'd0;
			pc = npc;
			npc = nextNpc;
			steps++;
		end
	endfunction

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkEvent(input string addrSig, input string dataSig,
		input logic [31:0] addr, input logic [31:0] data);
		assert (nextEvent < expAddr.size())
		else failRun($sformatf("unexpected write to %h after the last expected one", addr));
		assert (addr == expAddr[nextEvent])
		else failRun($sformatf("MISMATCH at %0t: %s got %h expected %h",
			$time, addrSig, addr, expAddr[nextEvent]));
		assert (data == expData[nextEvent])
		else failRun($sformatf("MISMATCH at %0t: %s got %h expected %h",
			$time, dataSig, data, expData[nextEvent]));
		nextEvent++;
	endtask

	// gp events come from the previous cycle, so they are checked first
	always @(posedge clk) begin
		if (rst) begin
			nextEvent = 0;
			lastFrame = 32'd0;
		end else begin
			if (gpFrame != lastFrame) begin
				checkEvent("gpFrame address", "gpFrame", `GP_FRAME_ADDR, gpFrame);
				lastFrame = gpFrame;
			end
			if (gpValid) begin
				checkEvent("gpValid address", "gpCode", `GP_CODE_ADDR, gpCode);
			end
			if (dcacheWe) begin
				checkEvent("dcacheAddr", "dcacheDin", dcacheAddr, dcacheDin);
			end
		end
	end

	initial begin
		logic [31:0] frames;
		int cyc;
		rst = 1'b1;
		stall = 1'b0;
		frameInterrupt = 1'b0;
		seedMem = 1'b0;
		void'($urandom(33506));
		buildProgram();
		// run 0 without stall and run 1 with random stall
		for (int run = 0; run < 2; run++) begin
			frames = 32'd0;
			for (int c = 0; c < WINDOW; c++) begin
				irqWin[c] = 1'($urandom_range(0, 1));
				stallWin[c] = (run == 1) && ($urandom_range(0, 2) == 0);
				if (irqWin[c] && !stallWin[c]) begin
					frames = frames + 32'd1;
				end
			end
			modelRun(frames);
			@(posedge clk);
			rst <= 1'b1;
			seedMem <= 1'b1;
			stall <= 1'b0;
			frameInterrupt <= 1'b0;
			@(posedge clk);
			seedMem <= 1'b0;
			@(posedge clk);
			rst <= 1'b0;
			cyc = 0;
			do begin
				if (cyc < WINDOW) begin
					stall <= stallWin[cyc];
					frameInterrupt <= irqWin[cyc];
				end else begin
					stall <= (run == 1) && ($urandom_range(0, 2) == 0);
					frameInterrupt <= 1'b0;
				end
				cyc++;
				@(posedge clk);
			end while (nextEvent < expAddr.size());
			stall <= 1'b0;
		end
		$display("All tests passed");
		$finish;
	end

	// two runs of 40 cycles per instruction each
	initial begin
		wait (progLen > 0);
		repeat (2 * 40 * progLen) @(posedge clk);
		failRun("timeout: not all expected writes appeared in time");
	end

endmodule

//--- test/mipsLite_asserts.sv
`include "mipsLite_cfg.svh"

module mipsLiteAsserts (
	input logic clk,
	input logic rst,
	input logic dcacheWe,
	input logic dcacheRe,
	input logic [31:0] dcacheAddr,
	input logic gpValid
);
	timeunit 1ns;
	timeprecision 100ps;

	gpPulse: assert property (@(posedge clk) disable iff (rst) gpValid |=> !gpValid)
	else $error("gpValid stayed high for more than one cycle");

	weReExclusive: assert property (@(posedge clk) disable iff (rst) !(dcacheWe && dcacheRe))
	else $error("dcacheWe and dcacheRe high together");

	// device region is decoded inside the core
	noDeviceAccess: assert property (@(posedge clk) disable iff (rst)
		(dcacheWe || dcacheRe) |-> (dcacheAddr[31:28] != `DEVICE_NIBBLE))
	else $error("device address sent to data memory");

	quietInReset: assert property (@(posedge clk) rst |=> (!dcacheWe && !dcacheRe && !gpValid))
	else $error("control outputs active during reset");

endmodule

bind mipsLite mipsLiteAsserts checks (
	.clk(clk),
	.rst(rst),
	.dcacheWe(dcacheWe),
	.dcacheRe(dcacheRe),
	.dcacheAddr(dcacheAddr),
	.gpValid(gpValid)
);

//--- source/mipsLite.sv
module mipsLite (
	input logic clk,
	input logic rst,
	input logic stall,
	input logic frameInterrupt,
	input logic [31:0] instruction,
	output logic [31:0] icacheAddr,
	output logic [31:0] dcacheAddr,
	output logic dcacheWe,
	output logic dcacheRe,
	output logic [31:0] dcacheDin,
	input logic [31:0] dcacheDout,
	output logic [31:0] gpCode,
	output logic [31:0] gpFrame,
	output logic gpValid
);

	logic [31:0] instY;
	logic [31:0] pcPlus4Y;
	logic redirect;
	logic [31:0] target;
	logic [31:0] linkAddr;
	logic [31:0] rs;
	logic [31:0] rt;
	logic [31:0] aluOut;
	logic wbEn;
	logic [4:0] wbAddr;
	logic [31:0] wbData;

	execCtrlIf ctrl ();

	fetchUnit fetch (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.instruction(instruction),
		.redirect(redirect),
		.target(target),
		.icacheAddr(icacheAddr),
		.pcPlus4Y(pcPlus4Y),
		.instY(instY)
	);

	controlUnit control (
		.instY(instY),
		.ctrl(ctrl)
	);

	regFile regs (
		.clk(clk),
		.instY(instY),
		.wbEn(wbEn),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.rs(rs),
		.rt(rt)
	);

	aluUnit alu (
		.ctrl(ctrl.alu),
		.rs(rs),
		.rt(rt),
		.instY(instY),
		.aluOut(aluOut)
	);

	branchUnit branch (
		.ctrl(ctrl.branch),
		.rs(rs),
		.rt(rt),
		.instY(instY),
		.pcPlus4Y(pcPlus4Y),
		.redirect(redirect),
		.target(target),
		.linkAddr(linkAddr)
	);

	writebackUnit writeback (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.ctrl(ctrl.wb),
		.aluOut(aluOut),
		.linkAddr(linkAddr),
		.rt(rt),
		.dcacheDout(dcacheDout),
		.frameInterrupt(frameInterrupt),
		.dcacheAddr(dcacheAddr),
		.dcacheWe(dcacheWe),
		.dcacheRe(dcacheRe),
		.dcacheDin(dcacheDin),
		.wbEn(wbEn),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.gpCode(gpCode),
		.gpFrame(gpFrame),
		.gpValid(gpValid)
	);

endmodule

//--- source/writebackUnit.sv
`include "mipsLite_cfg.svh"

module writebackUnit (
	input logic clk,
	input logic rst,
	input logic stall,
	execCtrlIf.wb ctrl,
	input logic [31:0] aluOut,
	input logic [31:0] linkAddr,
	input logic [31:0] rt,
	input logic [31:0] dcacheDout,
	input logic frameInterrupt,
	output logic [31:0] dcacheAddr,
	output logic dcacheWe,
	output logic dcacheRe,
	output logic [31:0] dcacheDin,
	output logic wbEn,
	output logic [4:0] wbAddr,
	output logic [31:0] wbData,
	output logic [31:0] gpCode,
	output logic [31:0] gpFrame,
	output logic gpValid
);

	logic regWriteZ;
	logic memToRegZ;
	logic linkZ;
	logic [4:0] destRegZ;
	logic [31:0] aluOutZ;
	logic [31:0] linkAddrZ;
	logic [31:0] frameCount;
	logic deviceY;
	logic deviceZ;
	logic storeY;

	assign deviceY = (aluOut[31:28] == `DEVICE_NIBBLE);
	assign deviceZ = (aluOutZ[31:28] == `DEVICE_NIBBLE);
	assign storeY = ctrl.memWrite && !stall;

	// stalled: keep the z load address so its data stays valid
	assign dcacheAddr = stall ? aluOutZ : aluOut;
	assign dcacheWe = storeY && !deviceY;
	assign dcacheRe = stall ? (memToRegZ && !deviceZ) : (ctrl.memToReg && !deviceY);
	assign dcacheDin = rt;

	always_ff @(posedge clk) begin
		if (rst) begin
			regWriteZ <= 1'b0;
			memToRegZ <= 1'b0;
			linkZ <= 1'b0;
		end else if (!stall) begin
			regWriteZ <= ctrl.regWrite;
			memToRegZ <= ctrl.memToReg;
			linkZ <= ctrl.link;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			destRegZ <= ctrl.destReg;
			aluOutZ <= aluOut;
			linkAddrZ <= linkAddr;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			gpCode <= 32'd0;
			gpFrame <= 32'd0;
			gpValid <= 1'b0;
			frameCount <= 32'd0;
		end else begin
			// single pulse even if the next cycle stalls
			gpValid <= storeY && (aluOut == `GP_CODE_ADDR);
			if (!stall) begin
				if (ctrl.memWrite && (aluOut == `GP_CODE_ADDR)) begin
					gpCode <= rt;
				end
				if (ctrl.memWrite && (aluOut == `GP_FRAME_ADDR)) begin
					gpFrame <= rt;
				end
				frameCount <= frameCount + {31'd0, frameInterrupt};
			end
		end
	end

	always_comb begin
		if (linkZ) begin
			wbData = linkAddrZ;
		end else if (memToRegZ && deviceZ) begin
			wbData = (aluOutZ == `FRAME_COUNT_ADDR) ? frameCount : 32'd0;
		end else if (memToRegZ) begin
			wbData = dcacheDout;
		end else begin
			wbData = aluOutZ;
		end
	end

	assign wbEn = regWriteZ && !stall;
	assign wbAddr = destRegZ;

endmodule

//--- source/fetchUnit.sv
`include "mipsLite_cfg.svh"

module fetchUnit (
	input logic clk,
	input logic rst,
	input logic stall,
	input logic [31:0] instruction,
	input logic redirect,
	input logic [31:0] target,
	output logic [31:0] icacheAddr,
	output logic [31:0] pcPlus4Y,
	output logic [31:0] instY
);

	logic [31:0] pc;
	logic [31:0] pcPlus4;
	logic [31:0] nextPc;

	assign pcPlus4 = pc + 32'd4;
	// a redirect from y skips nothing, the slot is already in x
	assign nextPc = redirect ? target : pcPlus4;
	assign icacheAddr = pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `RESET_VECTOR;
			instY <= 32'd0;
		end else if (!stall) begin
			pc <= nextPc;
			instY <= instruction;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			pcPlus4Y <= pcPlus4;
		end
	end

endmodule

//--- source/branchUnit.sv
module branchUnit (
	execCtrlIf.branch ctrl,
	input logic [31:0] rs,
	input logic [31:0] rt,
	input logic [31:0] instY,
	input logic [31:0] pcPlus4Y,
	output logic redirect,
	output logic [31:0] target,
	output logic [31:0] linkAddr
);
	import mipsLitePkg::*;

	logic equal;
	logic [31:0] offset;

	assign equal = (rs == rt);
	assign offset = {{14{instY[15]}}, instY[15:0], 2'b00};

	always_comb begin
		redirect = 1'b0;
		target = pcPlus4Y + offset;
		case (ctrl.branchKind)
			BR_EQ: redirect = equal;
			BR_NE: redirect = !equal;
			BR_JUMP: begin
				redirect = 1'b1;
				// region bits come from the delay slot address
				target = {pcPlus4Y[31:28], instY[25:0], 2'b00};
			end
			BR_JUMPREG: begin
				redirect = 1'b1;
				target = rs;
			end
			default: redirect = 1'b0;
		endcase
	end

	// return past the delay slot
	assign linkAddr = ctrl.link ? pcPlus4Y + 32'd4 : 32'd0;

endmodule

//--- source/aluUnit.sv
module aluUnit (
	execCtrlIf.alu ctrl,
	input logic [31:0] rs,
	input logic [31:0] rt,
	input logic [31:0] instY,
	output logic [31:0] aluOut
);
	import mipsLitePkg::*;

	logic [31:0] opB;

	always_comb begin
		case (ctrl.srcB)
			SRC_RT: opB = rt;
			SRC_SIMM: opB = {{16{instY[15]}}, instY[15:0]};
			SRC_ZIMM: opB = {16'd0, instY[15:0]};
			default: opB = {27'd0, instY[10:6]};
		endcase
	end

	always_comb begin
		case (ctrl.aluOp)
			ALU_ADD: aluOut = rs + opB;
			ALU_SUB: aluOut = rs - opB;
			ALU_AND: aluOut = rs & opB;
			ALU_OR: aluOut = rs | opB;
			ALU_XOR: aluOut = rs ^ opB;
			ALU_SLT: aluOut = {31'd0, $signed(rs) < $signed(opB)};
			// shifts move rt by the shamt field
			ALU_SLL: aluOut = rt << opB[4:0];
			ALU_SRL: aluOut = rt >> opB[4:0];
			ALU_LUI: aluOut = {opB[15:0], 16'd0};
			default: aluOut = rs + opB;
		endcase
	end

endmodule

//--- source/regFile.sv
module regFile (
	input logic clk,
	input logic [31:0] instY,
	input logic wbEn,
	input logic [4:0] wbAddr,
	input logic [31:0] wbData,
	output logic [31:0] rs,
	output logic [31:0] rt
);

	logic [31:0] regs [32];
	logic [4:0] rsAddr;
	logic [4:0] rtAddr;

	assign rsAddr = instY[25:21];
	assign rtAddr = instY[20:16];

	always_ff @(posedge clk) begin
		if (wbEn && (wbAddr != 5'd0)) begin
			regs[wbAddr] <= wbData;
		end
	end

	// z result bypasses the array in the same cycle
	assign rs = (rsAddr == 5'd0) ? 32'd0 :
		(wbEn && (wbAddr == rsAddr)) ? wbData : regs[rsAddr];
	assign rt = (rtAddr == 5'd0) ? 32'd0 :
		(wbEn && (wbAddr == rtAddr)) ? wbData : regs[rtAddr];

endmodule

//--- source/controlUnit.sv
module controlUnit (
	input logic [31:0] instY,
	execCtrlIf ctrl
);
	import mipsLitePkg::*;

	logic writes;
	logic useRd;
	logic [4:0] dest;

	always_comb begin
		ctrl.aluOp = ALU_ADD;
		ctrl.srcB = SRC_RT;
		ctrl.branchKind = BR_NONE;
		ctrl.memToReg = 1'b0;
		ctrl.memWrite = 1'b0;
		ctrl.link = 1'b0;
		writes = 1'b0;
		useRd = 1'b0;
		case (instY[31:26])
			OP_RTYPE: begin
				writes = 1'b1;
				useRd = 1'b1;
				case (instY[5:0])
					FN_ADDU: ctrl.aluOp = ALU_ADD;
					FN_SUBU: ctrl.aluOp = ALU_SUB;
					FN_AND: ctrl.aluOp = ALU_AND;
					FN_OR: ctrl.aluOp = ALU_OR;
					FN_XOR: ctrl.aluOp = ALU_XOR;
					FN_SLT: ctrl.aluOp = ALU_SLT;
					FN_SLL: begin
						ctrl.aluOp = ALU_SLL;
						ctrl.srcB = SRC_SHAMT;
					end
					FN_SRL: begin
						ctrl.aluOp = ALU_SRL;
						ctrl.srcB = SRC_SHAMT;
					end
					FN_JR: begin
						writes = 1'b0;
						ctrl.branchKind = BR_JUMPREG;
					end
					default: writes = 1'b0;
				endcase
			end
			OP_ADDIU: begin
				writes = 1'b1;
				ctrl.srcB = SRC_SIMM;
			end
			OP_ORI: begin
				writes = 1'b1;
				ctrl.aluOp = ALU_OR;
				ctrl.srcB = SRC_ZIMM;
			end
			OP_LUI: begin
				writes = 1'b1;
				ctrl.aluOp = ALU_LUI;
				ctrl.srcB = SRC_ZIMM;
			end
			OP_LW: begin
				writes = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.srcB = SRC_SIMM;
			end
			OP_SW: begin
				ctrl.memWrite = 1'b1;
				ctrl.srcB = SRC_SIMM;
			end
			OP_BEQ: ctrl.branchKind = BR_EQ;
			OP_BNE: ctrl.branchKind = BR_NE;
			OP_J: ctrl.branchKind = BR_JUMP;
			OP_JAL: begin
				writes = 1'b1;
				ctrl.link = 1'b1;
				ctrl.branchKind = BR_JUMP;
			end
			default: writes = 1'b0;
		endcase
	end

	// r31 for jal, rd for r-type, rt otherwise
	assign dest = ctrl.link ? 5'd31 : (useRd ? instY[15:11] : instY[20:16]);
	assign ctrl.destReg = dest;
	assign ctrl.regWrite = writes && (dest != 5'd0);

endmodule

//--- source/execCtrlIf.sv
interface execCtrlIf;
	import mipsLitePkg::*;

	aluOpT aluOp;
	srcBT srcB;
	branchT branchKind;
	logic regWrite;
	logic memToReg;
	logic memWrite;
	// jal, writes the link address to r31
	logic link;
	logic [4:0] destReg;

	modport alu (
		input aluOp,
		input srcB
	);

	modport branch (
		input branchKind,
		input link
	);

	modport wb (
		input regWrite,
		input memToReg,
		input memWrite,
		input link,
		input destReg
	);

endinterface

//--- source/mipsLitePkg.sv
package mipsLitePkg;

	// primary opcodes, instY[31:26]
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J = 6'h02,
		OP_JAL = 6'h03,
		OP_BEQ = 6'h04,
		OP_BNE = 6'h05,
		OP_ADDIU = 6'h09,
		OP_ORI = 6'h0d,
		OP_LUI = 6'h0f,
		OP_LW = 6'h23,
		OP_SW = 6'h2b
	} opcodeT;

	// r-type function field, instY[5:0]
	typedef enum logic [5:0] {
		FN_SLL = 6'h00,
		FN_SRL = 6'h02,
		FN_JR = 6'h08,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND = 6'h24,
		FN_OR = 6'h25,
		FN_XOR = 6'h26,
		FN_SLT = 6'h2a
	} functT;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_LUI
	} aluOpT;

	typedef enum logic [1:0] {
		SRC_RT,
		SRC_SIMM,
		SRC_ZIMM,
		SRC_SHAMT
	} srcBT;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_EQ,
		BR_NE,
		BR_JUMP,
		BR_JUMPREG
	} branchT;

endpackage

//--- source/mipsLite_cfg.svh
`ifndef MIPSLITE_CFG_SVH
`define MIPSLITE_CFG_SVH

// first fetch address after reset
`define RESET_VECTOR 32'h4000_0000

// memory mapped graphics and frame counter
`define GP_CODE_ADDR 32'h8000_0030
`define GP_FRAME_ADDR 32'h8000_0040
`define FRAME_COUNT_ADDR 32'h8000_0050

// top nibble of the device region, never sent to data memory
`define DEVICE_NIBBLE 4'h8

`endif
